//--- hw/coreDefs.sv
package coreDefs;

    // Datapath sizes
    localparam int dataWidth    = 32;
    localparam int regCount     = 17;   // r0..r15 visible, entry 16 hidden
    localparam int regNumWidth  = 4;
    localparam int specialWidth = 4;

    // Instruction field positions
    localparam int opMsb  = 31;
    localparam int opLsb  = 28;
    localparam int rdMsb  = 27;
    localparam int rdLsb  = 24;
    localparam int rs1Msb = 23;
    localparam int rs1Lsb = 20;
    localparam int rs2Msb = 19;
    localparam int rs2Lsb = 16;
    localparam int immMsb = 15;
    localparam int immLsb = 0;
    localparam int immWidth = immMsb - immLsb + 1;

    // Special register numbers
    localparam logic [regNumWidth-1:0] pcReg       = 4'd15;
    localparam logic [regNumWidth-1:0] spReg       = 4'd14;
    localparam logic [regNumWidth-1:0] lrReg       = 4'd13;
    localparam logic [regNumWidth-1:0] sysCallReg  = 4'd7;
    localparam logic [regNumWidth-1:0] savedSpReg  = 4'd5;
    localparam logic [4:0]             kernelSpIndex = 5'd16; // Hidden kernel SP

    // Reset and entry constants
    localparam logic [dataWidth-1:0] userStackInit   = 32'd8191;
    localparam logic [dataWidth-1:0] kernelStackInit = 32'd6143;
    localparam logic [dataWidth-1:0] pcInit          = 32'd1;
    localparam logic [dataWidth-1:0] osStart         = 32'd2048;

    typedef enum logic [3:0] {
        opAdd         = 4'd0,
        opSub         = 4'd1,
        opAnd         = 4'd2,
        opOr          = 4'd3,
        opXor         = 4'd4,
        opAddi        = 4'd5,   // rd = rs1 + imm
        opLoad        = 4'd6,   // rd = mem[rs1 + imm]
        opBeq         = 4'd7,   // PC += imm when rs1 == rs2
        opSysCall     = 4'd8,
        opSysRet      = 4'd9,
        opCopySpecial = 4'd10,  // rd = zero-extended special reg
        opNop         = 4'd11
    } opcodeT;

    // How the bank retires an instruction
    typedef enum logic [2:0] {
        wbAlu     = 3'd0,
        wbMem     = 3'd1,
        wbSysCall = 3'd2,
        wbSysRet  = 3'd3,
        wbSpecial = 3'd4,
        wbNone    = 3'd5
    } wbKindT;

endpackage

//--- hw/instrDecode.sv
`timescale 1ns/100ps

module instrDecode
    import coreDefs::*;
(
    input  logic                   fast_clock,
    input  logic                   reset,
    input  logic                   instrValid,
    input  logic [dataWidth-1:0]   instrWord,
    output logic                   decValid,
    output opcodeT                 decOp,
    output wbKindT                 decWbKind,
    output logic [regNumWidth-1:0] decRd,
    output logic [regNumWidth-1:0] decRs1,
    output logic [regNumWidth-1:0] decRs2,
    output logic [dataWidth-1:0]   decImm
);

    logic [3:0]           rawOp;
    opcodeT               legalOp;
    wbKindT               wbKind;
    logic [dataWidth-1:0] immExt;

    assign rawOp  = instrWord[opMsb:opLsb];
    assign immExt = {{(dataWidth-immWidth){instrWord[immMsb]}}, instrWord[immMsb:immLsb]};

    // Unused opcode space decodes as a no-op
    always_comb begin
        case (rawOp)
            opAdd, opSub, opAnd, opOr, opXor,
            opAddi, opLoad, opBeq, opSysCall,
            opSysRet, opCopySpecial, opNop: legalOp = opcodeT'(rawOp);
            default:                        legalOp = opNop;
        endcase
    end

    always_comb begin
        case (legalOp)
            opLoad:        wbKind = wbMem;
            opSysCall:     wbKind = wbSysCall;
            opSysRet:      wbKind = wbSysRet;
            opCopySpecial: wbKind = wbSpecial;
            opBeq, opNop:  wbKind = wbNone;     // PC update only
            default:       wbKind = wbAlu;
        endcase
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid;             // One-cycle strobe
        end
    end

    // Fields stay put until the next instruction
    always_ff @(posedge fast_clock) begin
        if (instrValid) begin
            decOp     <= legalOp;
            decWbKind <= wbKind;
            decRd     <= instrWord[rdMsb:rdLsb];
            decRs1    <= instrWord[rs1Msb:rs1Lsb];
            decRs2    <= instrWord[rs2Msb:rs2Lsb];
            decImm    <= immExt;
        end
    end

    // No hazard logic, so strobes must be spaced by the pipeline depth
    instrSpacing: assert property (
        @(posedge fast_clock) disable iff (reset)
        instrValid |=> !instrValid [*3]
    ) else $error("instrValid strobes closer than four cycles");

endmodule

//--- hw/execUnit.sv
`timescale 1ns/100ps

module execUnit
    import coreDefs::*;
(
    input  logic                   fast_clock,
    input  logic                   reset,
    input  logic                   decValid,
    input  opcodeT                 decOp,
    input  wbKindT                 decWbKind,
    input  logic [regNumWidth-1:0] decRd,
    input  logic [dataWidth-1:0]   decImm,
    input  logic [dataWidth-1:0]   readDataA,
    input  logic [dataWidth-1:0]   readDataB,
    input  logic [dataWidth-1:0]   pcValue,
    output logic                   exValid,
    output wbKindT                 exWbKind,
    output logic [regNumWidth-1:0] exRd,
    output logic [dataWidth-1:0]   exResult,
    output logic [dataWidth-1:0]   exNextPc,
    output logic [dataWidth-1:0]   exSysNum,
    output logic                   memRead,
    output logic [dataWidth-1:0]   memAddr
);

    logic                   s1Valid;
    opcodeT                 s1Op;
    wbKindT                 s1WbKind;
    logic [regNumWidth-1:0] s1Rd;
    logic [dataWidth-1:0]   s1Imm;

    logic [dataWidth-1:0]   offsetSum;
    logic [dataWidth-1:0]   aluResult;
    logic                   branchTaken;
    logic [dataWidth-1:0]   nextPc;

    // Delay decode by one cycle to meet the registered bank reads
    always_ff @(posedge fast_clock) begin
        if (reset) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= decValid;
        end
    end

    always_ff @(posedge fast_clock) begin
        if (decValid) begin
            s1Op     <= decOp;
            s1WbKind <= decWbKind;
            s1Rd     <= decRd;
            s1Imm    <= decImm;
        end
    end

    assign offsetSum = readDataA + s1Imm;   // addi result and load address

    always_comb begin
        case (s1Op)
            opAdd:          aluResult = readDataA + readDataB;
            opSub:          aluResult = readDataA - readDataB;
            opAnd:          aluResult = readDataA & readDataB;
            opOr:           aluResult = readDataA | readDataB;
            opXor:          aluResult = readDataA ^ readDataB;
            opAddi, opLoad: aluResult = offsetSum;
            default:        aluResult = '0;
        endcase
    end

    assign branchTaken = (s1Op == opBeq) && (readDataA == readDataB);
    assign nextPc      = branchTaken ? pcValue + s1Imm : pcValue + 1'b1;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            exValid <= 1'b0;
            memRead <= 1'b0;
        end else begin
            exValid <= s1Valid;
            memRead <= s1Valid && (s1Op == opLoad);
        end
    end

    always_ff @(posedge fast_clock) begin
        if (s1Valid) begin
            exWbKind <= s1WbKind;
            exRd     <= s1Rd;
            exResult <= aluResult;
            exNextPc <= nextPc;     // Also the return address on a syscall
            exSysNum <= s1Imm;
            memAddr  <= offsetSum;
        end
    end

    // A read strobe belongs to a retiring load and lasts one cycle
    loadStrobe: assert property (
        @(posedge fast_clock) disable iff (reset)
        memRead |-> (exValid && exWbKind == wbMem) ##1 !memRead
    ) else $error("memRead not tied to a single load");

endmodule

//--- hw/regBank.sv
`timescale 1ns/100ps

module regBank
    import coreDefs::*;
(
    input  logic                    fast_clock,
    input  logic                    reset,
    input  logic [regNumWidth-1:0]  decRs1,
    input  logic [regNumWidth-1:0]  decRs2,
    input  logic                    exValid,
    input  wbKindT                  exWbKind,
    input  logic [regNumWidth-1:0]  exRd,
    input  logic [dataWidth-1:0]    exResult,
    input  logic [dataWidth-1:0]    exNextPc,
    input  logic [dataWidth-1:0]    exSysNum,
    input  logic [dataWidth-1:0]    memReadData,
    input  logic [specialWidth-1:0] specialReg,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB,
    output logic [dataWidth-1:0]    pcValue,
    output logic [dataWidth-1:0]    currentPc,
    output logic [dataWidth-1:0]    currentSp,
    output logic                    retired,
    output logic [regNumWidth-1:0]  retiredDest,
    output logic [dataWidth-1:0]    retiredValue
);

    logic [dataWidth-1:0]   bank [regCount];

    logic                   rdWritable;
    logic                   writesRd;
    logic [dataWidth-1:0]   writeData;
    logic [dataWidth-1:0]   newPc;
    logic [regNumWidth-1:0] retireDest;
    logic [dataWidth-1:0]   retireValue;

    // SP and PC are only changed through the dedicated paths
    assign rdWritable = (exRd != spReg) && (exRd != pcReg);
    assign writesRd   = (exWbKind == wbAlu) || (exWbKind == wbMem) ||
                        (exWbKind == wbSpecial);

    always_comb begin
        case (exWbKind)
            wbMem:     writeData = memReadData;
            wbSpecial: writeData = {{(dataWidth-specialWidth){1'b0}}, specialReg};
            default:   writeData = exResult;
        endcase
    end

    always_comb begin
        case (exWbKind)
            wbSysCall: newPc = osStart;
            wbSysRet:  newPc = bank[lrReg];     // Back to the caller
            default:   newPc = exNextPc;
        endcase
    end

    // Syscall, sysret and no-op report the PC as their result
    assign retireDest  = writesRd ? exRd : pcReg;
    assign retireValue = writesRd ? writeData : newPc;

    // Registered read ports
    always_ff @(posedge fast_clock) begin
        readDataA <= bank[decRs1];
        readDataB <= bank[decRs2];
        pcValue   <= bank[pcReg];
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                bank[i] <= '0;
            end
            bank[spReg]         <= userStackInit;
            bank[pcReg]         <= pcInit;
            bank[kernelSpIndex] <= kernelStackInit;
        end else if (exValid) begin
            case (exWbKind)
                wbAlu, wbMem, wbSpecial: begin
                    if (rdWritable) begin
                        bank[exRd] <= writeData;
                    end
                    bank[pcReg] <= newPc;
                end
                wbSysCall: begin
                    bank[savedSpReg] <= bank[spReg];         // Keep user SP
                    bank[lrReg]      <= exNextPc;            // Return address
                    bank[spReg]      <= bank[kernelSpIndex]; // Kernel stack
                    bank[pcReg]      <= newPc;
                    bank[sysCallReg] <= exSysNum;
                end
                wbSysRet: begin
                    bank[kernelSpIndex] <= bank[spReg];
                    bank[spReg]         <= bank[savedSpReg];
                    bank[pcReg]         <= newPc;
                end
                default: begin
                    bank[pcReg] <= newPc;
                end
            endcase
        end
    end

    assign currentPc = bank[pcReg];
    assign currentSp = bank[spReg];

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            retired <= 1'b0;
        end else begin
            retired <= exValid;
        end
    end

    always_ff @(posedge fast_clock) begin
        if (exValid) begin
            retiredDest  <= retireDest;
            retiredValue <= retireValue;
        end
    end

    // PC moves only on a write-back and SP only on a system call or return
    protectedRegs: assert property (
        @(posedge fast_clock) disable iff (reset)
        !(exValid && (exWbKind == wbSysCall || exWbKind == wbSysRet)) |=>
            $stable(currentSp) && ($past(exValid) || $stable(currentPc))
    ) else $error("PC or SP changed outside its write-back path");

endmodule

//--- hw/coreTop.sv
`timescale 1ns/100ps

module coreTop
    import coreDefs::*;
(
    input  logic                    fast_clock,
    input  logic                    reset,
    input  logic                    instrValid,
    input  logic [dataWidth-1:0]    instrWord,
    input  logic [dataWidth-1:0]    memReadData,
    input  logic [specialWidth-1:0] specialReg,
    output logic [dataWidth-1:0]    memAddr,
    output logic                    memRead,
    output logic                    retired,
    output logic [regNumWidth-1:0]  retiredDest,
    output logic [dataWidth-1:0]    retiredValue,
    output logic [dataWidth-1:0]    currentPc,
    output logic [dataWidth-1:0]    currentSp
);

    // Decode stage
    logic                   decValid;
    opcodeT                 decOp;
    wbKindT                 decWbKind;
    logic [regNumWidth-1:0] decRd;
    logic [regNumWidth-1:0] decRs1;
    logic [regNumWidth-1:0] decRs2;
    logic [dataWidth-1:0]   decImm;

    // Execute stage
    logic                   exValid;
    wbKindT                 exWbKind;
    logic [regNumWidth-1:0] exRd;
    logic [dataWidth-1:0]   exResult;
    logic [dataWidth-1:0]   exNextPc;
    logic [dataWidth-1:0]   exSysNum;

    // Bank read ports
    logic [dataWidth-1:0]   readDataA;
    logic [dataWidth-1:0]   readDataB;
    logic [dataWidth-1:0]   pcValue;

    instrDecode u_instrDecode (
        .fast_clock (fast_clock),
        .reset      (reset),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .decValid   (decValid),
        .decOp      (decOp),
        .decWbKind  (decWbKind),
        .decRd      (decRd),
        .decRs1     (decRs1),
        .decRs2     (decRs2),
        .decImm     (decImm)
    );

    execUnit u_execUnit (
        .fast_clock (fast_clock),
        .reset      (reset),
        .decValid   (decValid),
        .decOp      (decOp),
        .decWbKind  (decWbKind),
        .decRd      (decRd),
        .decImm     (decImm),
        .readDataA  (readDataA),
        .readDataB  (readDataB),
        .pcValue    (pcValue),
        .exValid    (exValid),
        .exWbKind   (exWbKind),
        .exRd       (exRd),
        .exResult   (exResult),
        .exNextPc   (exNextPc),
        .exSysNum   (exSysNum),
        .memRead    (memRead),
        .memAddr    (memAddr)
    );

    regBank u_regBank (
        .fast_clock   (fast_clock),
        .reset        (reset),
        .decRs1       (decRs1),
        .decRs2       (decRs2),
        .exValid      (exValid),
        .exWbKind     (exWbKind),
        .exRd         (exRd),
        .exResult     (exResult),
        .exNextPc     (exNextPc),
        .exSysNum     (exSysNum),
        .memReadData  (memReadData),
        .specialReg   (specialReg),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .pcValue      (pcValue),
        .currentPc    (currentPc),
        .currentSp    (currentSp),
        .retired      (retired),
        .retiredDest  (retiredDest),
        .retiredValue (retiredValue)
    );

endmodule

//--- tests/tbCore.sv
`timescale 1ns/100ps

module tbCore
    import coreDefs::*;
();

    localparam int numRows    = 19;
    localparam int maxLatency = 8;      // Cycles allowed before retired

    logic                    fast_clock;
    logic                    reset;
    logic                    instrValid;
    logic [dataWidth-1:0]    instrWord;
    logic [dataWidth-1:0]    memReadData;
    logic [specialWidth-1:0] specialReg;
    logic [dataWidth-1:0]    memAddr;
    logic                    memRead;
    logic                    retired;
    logic [regNumWidth-1:0]  retiredDest;
    logic [dataWidth-1:0]    retiredValue;
    logic [dataWidth-1:0]    currentPc;
    logic [dataWidth-1:0]    currentSp;

    // Stimulus and expected results, one entry per instruction
    logic [31:0] rowWord    [numRows];
    logic [31:0] rowMem     [numRows];
    logic [3:0]  rowSpecial [numRows];
    logic [3:0]  rowDest    [numRows];
    logic [31:0] rowValue   [numRows];
    logic [31:0] rowPc      [numRows];
    logic [31:0] rowSp      [numRows];
    logic        rowLoad    [numRows];
    logic [31:0] rowMemAddr [numRows];

    int     rowCount;
    int     curRow;
    integer seed;

    coreTop u_coreTop (
        .fast_clock   (fast_clock),
        .reset        (reset),
        .instrValid   (instrValid),
        .instrWord    (instrWord),
        .memReadData  (memReadData),
        .specialReg   (specialReg),
        .memAddr      (memAddr),
        .memRead      (memRead),
        .retired      (retired),
        .retiredDest  (retiredDest),
        .retiredValue (retiredValue),
        .currentPc    (currentPc),
        .currentSp    (currentSp)
    );

    initial begin
        fast_clock = 1'b0;
        forever #20 fast_clock = ~fast_clock;   // 40 ns period
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t row %0d %s: got 0x%08h expected 0x%08h",
                     $time, curRow, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] encodeInstr(input opcodeT op, input logic [3:0] rd,
                                                input logic [3:0] rs1, input logic [3:0] rs2,
                                                input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic addRow(input logic [31:0] word, input logic [31:0] mem,
                          input logic [3:0] special, input logic [3:0] dest,
                          input logic [31:0] value, input logic [31:0] pc,
                          input logic [31:0] sp);
        rowWord[rowCount]    = word;
        rowMem[rowCount]     = mem;
        rowSpecial[rowCount] = special;
        rowDest[rowCount]    = dest;
        rowValue[rowCount]   = value;
        rowPc[rowCount]      = pc;
        rowSp[rowCount]      = sp;
        rowLoad[rowCount]    = 1'b0;
        rowMemAddr[rowCount] = 32'd0;
        rowCount++;
    endtask

    task automatic buildTable();
        logic [31:0] rnd;
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] valA;
        logic [31:0] valB;
        logic [31:0] loadData;
        rnd  = $random(seed);
        immA = rnd[15:0];
        rnd  = $random(seed);
        immB = rnd[15:0];
        if (immB == immA) begin
            immB = immA ^ 16'h0001;     // Not-taken branch needs unequal operands
        end
        rnd      = $random(seed);
        loadData = rnd;
        valA     = {{16{immA[15]}}, immA};
        valB     = {{16{immB[15]}}, immB};
        rowCount = 0;
        addRow(encodeInstr(opAddi, 4'd1, 4'd0, 4'd0, immA), 32'd0, 4'd0, 4'd1, valA, 2, 8191);
        addRow(encodeInstr(opAddi, 4'd2, 4'd0, 4'd0, immB), 32'd0, 4'd0, 4'd2, valB, 3, 8191);
        addRow(encodeInstr(opAdd, 4'd3, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd3, valA + valB,
               4, 8191);
        addRow(encodeInstr(opSub, 4'd4, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd4, valA - valB,
               5, 8191);
        addRow(encodeInstr(opAnd, 4'd6, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd6, valA & valB,
               6, 8191);
        addRow(encodeInstr(opOr, 4'd8, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd8, valA | valB,
               7, 8191);
        addRow(encodeInstr(opXor, 4'd9, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd9, valA ^ valB,
               8, 8191);
        // SP and PC ignore ALU writes but the PC still steps
        addRow(encodeInstr(opAddi, 4'd14, 4'd1, 4'd0, 16'd5), 32'd0, 4'd0, 4'd14,
               valA + 32'd5, 9, 8191);
        addRow(encodeInstr(opAdd, 4'd15, 4'd1, 4'd2, 16'd0), 32'd0, 4'd0, 4'd15,
               valA + valB, 10, 8191);
        addRow(encodeInstr(opLoad, 4'd10, 4'd1, 4'd0, 16'd16), loadData, 4'd0, 4'd10,
               loadData, 11, 8191);
        rowLoad[rowCount-1]    = 1'b1;
        rowMemAddr[rowCount-1] = valA + 32'd16;
        addRow(encodeInstr(opBeq, 4'd0, 4'd1, 4'd1, 16'd6), 32'd0, 4'd0, 4'd15, 17, 17, 8191);
        addRow(encodeInstr(opBeq, 4'd0, 4'd1, 4'd2, 16'd6), 32'd0, 4'd0, 4'd15, 18, 18, 8191);
        addRow(encodeInstr(opBeq, 4'd0, 4'd0, 4'd0, 16'hfffd), 32'd0, 4'd0, 4'd15, 15, 15,
               8191);                   // Backward branch by three
        addRow(encodeInstr(opSysCall, 4'd0, 4'd0, 4'd0, 16'd42), 32'd0, 4'd0, 4'd15, 2048,
               2048, 6143);
        addRow(encodeInstr(opCopySpecial, 4'd11, 4'd0, 4'd0, 16'd0), 32'd0, 4'h9, 4'd11, 9,
               2049, 6143);
        addRow(encodeInstr(opAddi, 4'd12, 4'd7, 4'd0, 16'd0), 32'd0, 4'd0, 4'd12, 42, 2050,
               6143);                   // Syscall number landed in r7
        addRow(encodeInstr(opAddi, 4'd3, 4'd5, 4'd0, 16'd0), 32'd0, 4'd0, 4'd3, 8191, 2051,
               6143);                   // Saved user SP in r5
        addRow(encodeInstr(opSysRet, 4'd0, 4'd0, 4'd0, 16'd0), 32'd0, 4'd0, 4'd15, 16, 16,
               8191);
        addRow({4'he, 28'd0}, 32'd0, 4'd0, 4'd15, 17, 17, 8191);   // Illegal opcode acts as nop
    endtask

    task automatic applyRow(input int r);
        int          cycles;
        logic        memSeen;
        logic [31:0] memAddrSeen;
        cycles      = 0;
        memSeen     = 1'b0;
        memAddrSeen = '0;
        @(posedge fast_clock);
        #2;
        instrValid  = 1'b1;
        instrWord   = rowWord[r];
        memReadData = rowMem[r];
        specialReg  = rowSpecial[r];
        @(posedge fast_clock);                  // E0 samples the strobe
        #2;
        instrValid = 1'b0;
        do begin
            @(negedge fast_clock);
            cycles++;
            if (memRead) begin
                memSeen     = 1'b1;
                memAddrSeen = memAddr;
            end
        end while (!retired && cycles < maxLatency);
        if (!retired) begin
            $display("Row %0d did not retire within %0d cycles", r, maxLatency);
            $display("TESTBENCH FAILED");
            $fatal(1, "retire timeout");
        end
        checkValue("retire latency", cycles - 1, 32'd3);
        checkValue("retiredDest", {28'd0, retiredDest}, {28'd0, rowDest[r]});
        checkValue("retiredValue", retiredValue, rowValue[r]);
        checkValue("currentPc", currentPc, rowPc[r]);
        checkValue("currentSp", currentSp, rowSp[r]);
        checkValue("memRead", {31'd0, memSeen}, {31'd0, rowLoad[r]});
        if (rowLoad[r]) begin
            checkValue("memAddr", memAddrSeen, rowMemAddr[r]);
        end
        @(negedge fast_clock);
        checkValue("retired", {31'd0, retired}, 32'd0);   // Single-cycle pulse
        @(negedge fast_clock);
    endtask

    initial begin
        seed        = 32'h8b4d;
        reset       = 1'b1;
        instrValid  = 1'b0;
        instrWord   = '0;
        memReadData = '0;
        specialReg  = '0;
        curRow      = -1;
        buildTable();
        repeat (2) @(posedge fast_clock);
        #2;
        reset = 1'b0;
        @(negedge fast_clock);
        checkValue("currentPc", currentPc, 32'd1);
        checkValue("currentSp", currentSp, 32'd8191);
        checkValue("retired", {31'd0, retired}, 32'd0);
        for (int r = 0; r < numRows; r++) begin
            curRow = r;
            applyRow(r);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Each row needs well under ten cycles
    initial begin
        repeat (numRows * 10 + 20) @(posedge fast_clock);
        $display("Watchdog expired before the instruction sequence finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- tb.f
hw/coreDefs.sv
hw/instrDecode.sv
hw/execUnit.sv
hw/regBank.sv
hw/coreTop.sv
tests/tbCore.sv

//--- Makefile
# Verilator build for the core testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tbCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)
SIM       ?= $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv) $(wildcard tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
